//--- rtl/acq_pkg.sv
package acq_pkg;

  localparam int SAMPLE_W = 16;
  localparam int LANES    = 2;                 // samples per stored word
  localparam int WORD_W   = SAMPLE_W * LANES;

  localparam int DEPTH    = 64;                // ring words
  localparam int ADDR_W   = $clog2(DEPTH);
  localparam int PRE_LEN  = 8;                 // pre-trigger history in words

  localparam int QUEUE_DEPTH = 4;
  localparam int QADDR_W     = $clog2(QUEUE_DEPTH);

endpackage

//--- rtl/sample_packer.sv
`timescale 1ns/1ns

module sample_packer
  import acq_pkg::*;
(
  input  logic                CLK,
  input  logic                RESET,
  input  logic [SAMPLE_W-1:0] sample_in,
  input  logic                sample_valid,
  input  logic                trig_in,
  output logic [WORD_W-1:0]   word_data,
  output logic                word_trig,
  output logic                word_we
);

  logic [$clog2(LANES)-1:0] lane_cnt;
  logic [SAMPLE_W-1:0]      hold;     // lane 0 waiting for its partner

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      lane_cnt  <= '0;
      word_we   <= 1'b0;
      word_trig <= 1'b0;
    end else begin
      word_we <= 1'b0;
      if (sample_valid) begin
        if (lane_cnt == LANES - 1) begin
          lane_cnt  <= '0;
          word_we   <= 1'b1;
          word_trig <= trig_in;   // level seen with the second sample
        end else begin
          lane_cnt <= lane_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (sample_valid) begin
      if (lane_cnt == LANES - 1) begin
        word_data <= {sample_in, hold};  // earlier sample in low half
      end else begin
        hold <= sample_in;
      end
    end
  end

endmodule

//--- rtl/record_queue.sv
`timescale 1ns/1ns

module record_queue
  import acq_pkg::*;
(
  input  logic              CLK,
  input  logic              RESET,
  input  logic              push,
  input  logic [ADDR_W-1:0] push_start,
  input  logic [ADDR_W-1:0] push_end,
  input  logic              pop,
  output logic [ADDR_W-1:0] head_start,
  output logic [ADDR_W-1:0] head_end,
  output logic              empty,
  output logic              full
);

  logic [ADDR_W-1:0]  q_start [QUEUE_DEPTH];
  logic [ADDR_W-1:0]  q_end [QUEUE_DEPTH];
  logic [QADDR_W-1:0] rd_ptr;
  logic [QADDR_W-1:0] wr_ptr;
  logic [QADDR_W:0]   count;

  assign head_start = q_start[rd_ptr];  // head shown without read delay
  assign head_end   = q_end[rd_ptr];
  assign empty      = (count == '0);
  assign full       = (count == QUEUE_DEPTH);

  always_ff @(posedge CLK) begin
    if (push) begin
      q_start[wr_ptr] <= push_start;
      q_end[wr_ptr]   <= push_end;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/capture_ring.sv
`timescale 1ns/1ns

module capture_ring
  import acq_pkg::*;
(
  input  logic              CLK,
  input  logic              RESET,
  input  logic [WORD_W-1:0] word_data,
  input  logic              word_trig,
  input  logic              word_we,
  input  logic              word_req,
  output logic [WORD_W-1:0] rd_data,
  output logic              rd_valid,
  output logic              rd_first,
  output logic              rd_last,
  output logic              rec_ready,
  output logic              overrun
);

  logic [WORD_W-1:0] mem [DEPTH];

  // write side
  logic [ADDR_W-1:0] wp;
  logic [ADDR_W-1:0] wp_next;
  logic              prev_trig;      // trigger of last written word
  logic [ADDR_W-1:0] hist_cnt;       // words since last boundary, saturates
  logic              rec_open;       // accepted trigger still high
  logic [ADDR_W-1:0] start_addr;
  logic              rise;
  logic              fall;
  logic              guard_on;
  logic [ADDR_W-1:0] prot_addr;
  logic              drop;
  logic              wr_ok;

  // record queue
  logic              q_push;
  logic              q_pop;
  logic              q_empty;
  logic              q_full;
  logic [ADDR_W-1:0] head_start;
  logic [ADDR_W-1:0] head_end;

  // read side
  logic              reading;
  logic [ADDR_W-1:0] rp;
  logic [ADDR_W-1:0] raddr;
  logic [ADDR_W-1:0] raddr_next;
  logic              at_end;
  logic              rd_go;

  assign wp_next = wp + 1'b1;
  assign rise    = word_we && word_trig && !prev_trig;
  assign fall    = word_we && !word_trig && prev_trig;
  assign q_push  = fall && rec_open && !q_full;

  assign rd_go      = word_req && !q_empty;
  assign raddr      = reading ? rp : head_start;   // first word comes from head
  assign raddr_next = raddr + 1'b1;
  assign at_end     = (raddr_next == head_end);
  assign q_pop      = rd_go && at_end;

  // oldest word not yet read out
  assign prot_addr = q_empty ? start_addr : raddr;
  assign guard_on  = rec_open || !q_empty;
  assign drop      = word_we && guard_on && (wp_next == prot_addr);
  assign wr_ok     = word_we && !drop;

  assign rec_ready = !q_empty;

  record_queue record_queue_i (
    .CLK        (CLK),
    .RESET      (RESET),
    .push       (q_push),
    .push_start (start_addr),
    .push_end   (wp),              // first untriggered word, exclusive
    .pop        (q_pop),
    .head_start (head_start),
    .head_end   (head_end),
    .empty      (q_empty),
    .full       (q_full)
  );

  always_ff @(posedge CLK) begin
    if (wr_ok) mem[wp] <= word_data;
    if (rd_go) rd_data <= mem[raddr];
  end

  always_ff @(posedge CLK) begin
    if (rise && !q_full) begin
      start_addr <= wp - hist_cnt;   // back PRE_LEN or to last boundary
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      wp        <= '0;
      prev_trig <= 1'b0;
      hist_cnt  <= '0;
      rec_open  <= 1'b0;
      overrun   <= 1'b0;
    end else begin
      if (wr_ok) wp <= wp_next;
      if (word_we) prev_trig <= word_trig;

      if (fall) begin
        hist_cnt <= {{(ADDR_W-1){1'b0}}, wr_ok};  // the fall word opens new history
      end else if (wr_ok && hist_cnt != PRE_LEN) begin
        hist_cnt <= hist_cnt + 1'b1;
      end

      if (rise && !q_full) begin
        rec_open <= 1'b1;
      end else if (fall) begin
        rec_open <= 1'b0;
      end

      if (drop) begin
        overrun <= 1'b1;
      end else if (!guard_on) begin
        overrun <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      reading  <= 1'b0;
      rp       <= '0;
      rd_valid <= 1'b0;
      rd_first <= 1'b0;
      rd_last  <= 1'b0;
    end else begin
      rd_valid <= rd_go;
      rd_first <= rd_go && !reading;
      rd_last  <= rd_go && at_end;
      if (rd_go) begin
        reading <= !at_end;    // entry popped after its last word
        rp      <= raddr_next;
      end
    end
  end

endmodule

//--- rtl/record_unpacker.sv
`timescale 1ns/1ns

module record_unpacker
  import acq_pkg::*;
(
  input  logic                CLK,
  input  logic                RESET,
  input  logic                rec_ready,
  input  logic [WORD_W-1:0]   rd_data,
  input  logic                rd_valid,
  input  logic                rd_first,
  input  logic                rd_last,
  output logic                word_req,
  output logic [SAMPLE_W-1:0] sample_out,
  output logic                sample_out_valid,
  output logic                rec_first,
  output logic                rec_last,
  output logic                rec_done
);

  logic                       run;        // requesting words of a record
  logic                       hold;       // wait for rec_done
  logic [$clog2(LANES)-1:0]   pace;
  logic [WORD_W-SAMPLE_W-1:0] rest;       // upper lane
  logic                       lane_pend;
  logic                       last_pend;

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      run      <= 1'b0;
      hold     <= 1'b0;
      pace     <= '0;
      word_req <= 1'b0;
    end else begin
      word_req <= 1'b0;
      if (run) begin
        pace <= pace + 1'b1;
        if (rd_valid && rd_last) begin
          run  <= 1'b0;
          hold <= 1'b1;
        end else if (pace == '0) begin
          word_req <= 1'b1;     // one word per LANES cycles
        end
      end else if (rec_ready && !hold) begin
        run  <= 1'b1;
        pace <= '0;
      end
      if (rec_done) hold <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      sample_out_valid <= 1'b0;
      rec_first        <= 1'b0;
      rec_last         <= 1'b0;
      rec_done         <= 1'b0;
      lane_pend        <= 1'b0;
      last_pend        <= 1'b0;
    end else begin
      rec_done <= rec_last;
      if (rd_valid) begin
        sample_out_valid <= 1'b1;
        rec_first        <= rd_first;
        rec_last         <= 1'b0;
        lane_pend        <= 1'b1;
        last_pend        <= rd_last;
      end else if (lane_pend) begin
        sample_out_valid <= 1'b1;
        rec_first        <= 1'b0;
        rec_last         <= last_pend;  // lane 1 of the last word
        lane_pend        <= 1'b0;
      end else begin
        sample_out_valid <= 1'b0;
        rec_first        <= 1'b0;
        rec_last         <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_valid) begin
      sample_out <= rd_data[SAMPLE_W-1:0];
      rest       <= rd_data[WORD_W-1:SAMPLE_W];
    end else if (lane_pend) begin
      sample_out <= rest[SAMPLE_W-1:0];
    end
  end

endmodule

//--- rtl/acq_top.sv
`timescale 1ns/1ns

module acq_top
  import acq_pkg::*;
(
  input  logic                CLK,
  input  logic                RESET,
  input  logic [SAMPLE_W-1:0] sample_in,
  input  logic                sample_valid,
  input  logic                trig_in,
  output logic [SAMPLE_W-1:0] sample_out,
  output logic                sample_out_valid,
  output logic                rec_first,
  output logic                rec_last,
  output logic                rec_done,
  output logic                overrun
);

  logic [WORD_W-1:0] word_data;
  logic              word_trig;
  logic              word_we;
  logic              word_req;
  logic [WORD_W-1:0] rd_data;
  logic              rd_valid;
  logic              rd_first;
  logic              rd_last;
  logic              rec_ready;

  sample_packer sample_packer_i (
    .CLK          (CLK),
    .RESET        (RESET),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .trig_in      (trig_in),
    .word_data    (word_data),
    .word_trig    (word_trig),
    .word_we      (word_we)
  );

  capture_ring capture_ring_i (
    .CLK       (CLK),
    .RESET     (RESET),
    .word_data (word_data),
    .word_trig (word_trig),
    .word_we   (word_we),
    .word_req  (word_req),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .rd_first  (rd_first),
    .rd_last   (rd_last),
    .rec_ready (rec_ready),
    .overrun   (overrun)
  );

  record_unpacker record_unpacker_i (
    .CLK              (CLK),
    .RESET            (RESET),
    .rec_ready        (rec_ready),
    .rd_data          (rd_data),
    .rd_valid         (rd_valid),
    .rd_first         (rd_first),
    .rd_last          (rd_last),
    .word_req         (word_req),
    .sample_out       (sample_out),
    .sample_out_valid (sample_out_valid),
    .rec_first        (rec_first),
    .rec_last         (rec_last),
    .rec_done         (rec_done)
  );

endmodule

//--- tests/acq_sva.sv
`timescale 1ns/1ns

module acq_sva (
  input logic CLK,
  input logic RESET,
  input logic sample_out_valid,
  input logic rec_last,
  input logic rec_done,
  input logic overrun
);

  done_after_last: assert property (@(posedge CLK) disable iff (!RESET)
    rec_last |=> rec_done)
    else $error("rec_done missing one cycle after rec_last");

  // gap between records
  quiet_after_done: assert property (@(posedge CLK) disable iff (!RESET)
    rec_done |=> !sample_out_valid)
    else $error("sample_out_valid high right after rec_done");

  no_overrun_in_reset: assert property (@(posedge CLK) !RESET |=> !overrun)
    else $error("overrun high while reset is asserted");

endmodule

bind acq_top acq_sva acq_sva_i (
  .CLK              (CLK),
  .RESET            (RESET),
  .sample_out_valid (sample_out_valid),
  .rec_last         (rec_last),
  .rec_done         (rec_done),
  .overrun          (overrun)
);

//--- tests/acq_tb.sv
`timescale 1ns/1ns

module acq_tb
  import acq_pkg::*;
();

  localparam int SEED      = 35690;
  localparam int LEN_SHORT = 11;    // words sent per test
  localparam int LEN_BASIC = 32;
  localparam int LEN_B2B   = 27;
  localparam int LEN_OVER  = 91;
  localparam int LEN_IDLE  = 100;
  localparam int MARGIN    = 200;
  localparam int LIMIT     = (LEN_SHORT + LEN_BASIC + LEN_B2B + LEN_OVER + LEN_IDLE) * 4
                             + MARGIN;

  logic                CLK;
  logic                RESET;
  logic [SAMPLE_W-1:0] sample_in;
  logic                sample_valid;
  logic                trig_in;
  logic [SAMPLE_W-1:0] sample_out;
  logic                sample_out_valid;
  logic                rec_first;
  logic                rec_last;
  logic                rec_done;
  logic                overrun;

  logic [SAMPLE_W-1:0] hist_q[$];   // history since last boundary
  logic [SAMPLE_W-1:0] cur_rec[$];
  logic [SAMPLE_W-1:0] exp_s[$];
  logic                exp_f[$];
  logic                exp_l[$];
  logic                m_trig = 1'b0;
  logic                m_open = 1'b0;
  logic                m_over = 1'b0;
  logic                done_due = 1'b0;

  string cur_test = "reset";
  int    errors = 0;
  int    err_mark = 0;
  int    tests_ok = 0;
  int    tests_bad = 0;
  int    recs_expected = 0;
  int    done_cnt = 0;
  int    samples_seen = 0;
  int    firsts_seen = 0;
  int    cycles = 0;

  acq_top acq_top_i (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  initial begin
    while (cycles < LIMIT) begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] exp,
                              input logic [SAMPLE_W-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // output side, outputs settle after posedge
  always @(negedge CLK) begin
    if (RESET) begin
      check_flag({cur_test, " rec_done"}, done_due, rec_done);
    end
    done_due = 1'b0;
    if (RESET && sample_out_valid) begin
      samples_seen++;
      if (exp_s.size() == 0) begin
        $display("error in %s: sample came out with no record expected", cur_test);
        errors++;
      end else begin
        done_due = exp_l[0];   // record closes, rec_done next cycle
        check_sample({cur_test, " sample_out"}, exp_s.pop_front(), sample_out);
        check_flag({cur_test, " rec_first"}, exp_f.pop_front(), rec_first);
        check_flag({cur_test, " rec_last"}, exp_l.pop_front(), rec_last);
      end
    end
    if (RESET && rec_first) firsts_seen++;
    if (RESET && rec_done) done_cnt++;
  end

  task automatic close_record();
    for (int i = 0; i < cur_rec.size(); i++) begin
      exp_s.push_back(cur_rec[i]);
      exp_f.push_back(i == 0);
      exp_l.push_back(i == cur_rec.size() - 1);
    end
    recs_expected++;
  endtask

  task automatic send_word(input logic trig);
    logic [SAMPLE_W-1:0] s0;
    logic [SAMPLE_W-1:0] s1;
    s0 = SAMPLE_W'($urandom);
    s1 = SAMPLE_W'($urandom);
    @(negedge CLK);
    sample_in    = s0;
    sample_valid = 1'b1;
    trig_in      = trig;
    @(negedge CLK);
    sample_in = s1;
    if (trig && !m_trig) begin
      cur_rec = hist_q;   // pre-trigger part
      m_open  = 1'b1;
    end
    if (trig && cur_rec.size() == 2 * (DEPTH - 1)) begin
      m_over = 1'b1;      // ring full, word dropped
    end else if (trig) begin
      cur_rec.push_back(s0);
      cur_rec.push_back(s1);
    end else if (m_trig && m_open) begin
      close_record();
      hist_q.delete();
      if (cur_rec.size() < 2 * (DEPTH - 1)) begin  // fall word kept unless ring full
        hist_q.push_back(s0);
        hist_q.push_back(s1);
      end
      m_open = 1'b0;
    end else begin
      hist_q.push_back(s0);
      hist_q.push_back(s1);
      if (hist_q.size() > 2 * PRE_LEN) begin
        void'(hist_q.pop_front());
        void'(hist_q.pop_front());
      end
    end
    m_trig = trig;
  endtask

  task automatic send_words(input int n, input logic trig);
    repeat (n) send_word(trig);
  endtask

  task automatic stop_input();
    @(negedge CLK);
    sample_valid = 1'b0;
    trig_in      = 1'b0;
  endtask

  task automatic wait_drain();
    wait (done_cnt == recs_expected);
    if (exp_s.size() != 0) begin
      $display("error in %s: record ended with %0d samples missing", cur_test, exp_s.size());
      errors++;
    end
    repeat (4) @(negedge CLK);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", cur_test, errors - err_mark);
    end
  endtask

  task automatic short_history();
    begin_test("short_history");
    send_words(3, 1'b0);
    send_words(6, 1'b1);
    send_words(2, 1'b0);
    stop_input();
    wait_drain();
    end_test();
  endtask

  task automatic basic_record();
    begin_test("basic_record");
    send_words(20, 1'b0);
    send_words(10, 1'b1);
    send_words(2, 1'b0);
    stop_input();
    wait_drain();
    end_test();
  endtask

  task automatic back_to_back();
    begin_test("back_to_back");
    send_words(10, 1'b0);
    send_words(5, 1'b1);
    send_words(4, 1'b0);   // only history of the second record
    send_words(6, 1'b1);
    send_words(2, 1'b0);
    stop_input();
    wait_drain();
    end_test();
  endtask

  task automatic overrun_hold();
    begin_test("overrun_hold");
    send_words(10, 1'b0);
    send_words(80, 1'b1);
    check_flag({cur_test, " overrun while held"}, m_over, overrun);
    send_words(1, 1'b0);
    stop_input();
    wait_drain();
    check_flag({cur_test, " overrun after drain"}, 1'b0, overrun);
    end_test();
  endtask

  task automatic idle_input();
    int seen;
    int firsts;
    begin_test("idle_input");
    seen   = samples_seen;
    firsts = firsts_seen;
    send_words(LEN_IDLE, 1'b0);
    stop_input();
    repeat (20) @(negedge CLK);
    @(posedge CLK);
    check_flag({cur_test, " sample_out_valid seen"}, 1'b0, samples_seen != seen);
    check_flag({cur_test, " rec_first seen"}, 1'b0, firsts_seen != firsts);
    end_test();
  endtask

  initial begin
    RESET        = 1'b0;
    sample_in    = '0;
    sample_valid = 1'b0;
    trig_in      = 1'b0;
    void'($urandom(SEED));
    repeat (16) @(negedge CLK);
    RESET = 1'b1;
    short_history();   // needs the reset point, so first
    basic_record();
    back_to_back();
    overrun_hold();
    idle_input();
    $display("summary: %0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad,
             errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
rtl/acq_pkg.sv
rtl/sample_packer.sv
rtl/record_queue.sv
rtl/capture_ring.sv
rtl/record_unpacker.sv
rtl/acq_top.sv
tests/acq_sva.sv
tests/acq_tb.sv

//--- Makefile
SIM      = verilator
TOP      = acq_tb
FILELIST = files.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
LOG      = sim.log
EXE      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(EXE) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
